// File: files.f
+incdir+design
design/ddr2_init_pkg.sv
design/ddr2_step_if.sv
design/ddr2_wait_timer.sv
design/ddr2_init_rom.sv
design/ddr2_init_sequencer.sv
design/ddr2_init_top.sv
test/ddr2_init_sva.sv
test/ddr2_init_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ddr2_init_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: test/ddr2_init_tb.sv
`timescale 1ns/1ps
`include "ddr2_init_defines.svh"

module ddr2_init_tb;
    import ddr2_init_pkg::*;

    localparam int unsigned power_up_cycles = 50;
    localparam ddr2_addr_t all_banks_addr = ddr2_addr_t'(1 << 10);

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic init = 1'b0;
    logic ready;
    logic csbar;
    logic rasbar;
    logic casbar;
    logic webar;
    logic cke;
    logic odt;
    ddr2_bank_t ba;
    ddr2_addr_t a;
    ddr2_cmd_t pin_cmd;

    // Expected command sequence, one row per init step.
    ddr2_cmd_t  exp_cmd [`DDR2_NUM_STEPS];
    ddr2_bank_t exp_bank [`DDR2_NUM_STEPS];
    ddr2_addr_t exp_addr [`DDR2_NUM_STEPS];
    int         exp_gap [`DDR2_NUM_STEPS];

    int idle_cycles;
    int gap_sum;
    int timeout_limit = 100000;
    int cycle_count = 0;
    int error_count = 0;
    int pass_count = 0;
    int fail_count = 0;
    int errors_before;
    int low_cycles;
    int settle_cycles;
    int held_cycles;
    int gap_cycles;
    int step;
    int cycle;

    ddr2_init_top #(
        .power_up_cycles (power_up_cycles)
    ) u_ddr2_init_top (
        .clk    (clk),
        .reset  (reset),
        .init   (init),
        .ready  (ready),
        .csbar  (csbar),
        .rasbar (rasbar),
        .casbar (casbar),
        .webar  (webar),
        .ba     (ba),
        .a      (a),
        .cke    (cke),
        .odt    (odt)
    );

    assign pin_cmd = {csbar, rasbar, casbar, webar};

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: the init sequence did not finish within %0d cycles", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s: got 0x%0h, expected 0x%0h", $time, what, actual,
                     expected);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_at_start);
        if (error_count == errors_at_start) begin
            pass_count++;
            $display("PASS: %s", name);
        end else begin
            fail_count++;
            $display("FAIL: %s (%0d errors)", name, error_count - errors_at_start);
        end
    endtask

    // MR fields: BL in A2-A0, BT in A3, CL in A6-A4, DLL reset in A8, WR in A11-A9.
    function automatic ddr2_addr_t mode_word(input bit dll_reset);
        int word;
        word = int'(`DDR2_BURST_LENGTH)
             | (int'(`DDR2_BURST_TYPE) << 3)
             | (int'(`DDR2_CAS_LATENCY) << 4)
             | (int'(dll_reset) << 8)
             | (int'(`DDR2_WRITE_RECOVERY) << 9);
        return ddr2_addr_t'(word);
    endfunction

    function automatic ddr2_addr_t extended_mode_word(input bit ocd_default);
        int word;
        word = (1 << 10) | (int'(`DDR2_ADDITIVE_LATENCY) << 3);
        if (ocd_default) begin
            word |= (7 << 7) | (1 << 2); // OCD calibration default.
        end
        return ddr2_addr_t'(word);
    endfunction

    task automatic set_row(input int index, input ddr2_cmd_t cmd, input ddr2_bank_t bank,
                           input ddr2_addr_t addr, input int gap);
        exp_cmd[index]  = cmd;
        exp_bank[index] = bank;
        exp_addr[index] = addr;
        exp_gap[index]  = gap;
    endtask

    task automatic build_expected_table();
        set_row(0, CMD_PRECHARGE, 2'd0, all_banks_addr, `DDR2_RP_GAP);
        set_row(1, CMD_LOAD_MODE, 2'd2, 13'h0000, `DDR2_MRD_GAP);
        set_row(2, CMD_LOAD_MODE, 2'd3, 13'h0000, `DDR2_MRD_GAP);
        set_row(3, CMD_LOAD_MODE, 2'd1, extended_mode_word(1'b0), `DDR2_MRD_GAP);
        set_row(4, CMD_LOAD_MODE, 2'd0, mode_word(1'b1), `DDR2_MRD_GAP);
        set_row(5, CMD_PRECHARGE, 2'd0, all_banks_addr, `DDR2_RP_GAP);
        set_row(6, CMD_REFRESH, 2'd0, 13'h0000, `DDR2_RFC_GAP);
        set_row(7, CMD_REFRESH, 2'd0, 13'h0000, `DDR2_RFC_GAP);
        set_row(8, CMD_LOAD_MODE, 2'd0, mode_word(1'b0), `DDR2_DLL_GAP);
        set_row(9, CMD_LOAD_MODE, 2'd1, extended_mode_word(1'b1), `DDR2_MRD_GAP);
        set_row(10, CMD_LOAD_MODE, 2'd1, extended_mode_word(1'b0), `DDR2_MRD_GAP);
        set_row(11, CMD_PRECHARGE, 2'd0, all_banks_addr, `DDR2_RP_GAP);
    endtask

    initial begin
        void'($urandom(21273));
        idle_cycles = 5 + int'($urandom % 36);
        build_expected_table();
        gap_sum = 0;
        for (step = 0; step < `DDR2_NUM_STEPS; step++) begin
            gap_sum += exp_gap[step];
        end
        timeout_limit = int'(power_up_cycles) + `DDR2_CKE_SETTLE_CYCLES
                      + `DDR2_NUM_STEPS * `DDR2_CMD_CYCLES + gap_sum + idle_cycles + 500;

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        errors_before = error_count;
        repeat (idle_cycles) begin
            @(negedge clk);
            check_value(32'({cke, odt, ready}), 0, "cke, odt and ready while idle");
            check_value(32'(pin_cmd), 32'(CMD_NOP), "command while idle");
        end
        @(posedge clk);
        init <= 1'b1;
        report_test("idle outputs with init low", errors_before);

        errors_before = error_count;
        @(posedge clk); // The sequencer sees init on this edge.
        low_cycles = 0;
        @(negedge clk);
        while (!cke) begin
            low_cycles++;
            check_value(32'(pin_cmd), 32'(CMD_NOP), "command during power-up");
            @(negedge clk);
        end
        check_value(low_cycles, power_up_cycles, "cke low cycles after init");
        settle_cycles = 0;
        while (pin_cmd == CMD_NOP) begin
            settle_cycles++;
            check_value(32'(cke), 1, "cke during settle");
            @(negedge clk);
        end
        check_value(settle_cycles, `DDR2_CKE_SETTLE_CYCLES, "NOP cycles after cke rises");
        report_test("power-up and cke settle", errors_before);

        for (step = 0; step < `DDR2_NUM_STEPS; step++) begin
            errors_before = error_count;
            check_value(32'(pin_cmd), 32'(exp_cmd[step]), $sformatf("step %0d command", step));
            check_value(32'(ba), 32'(exp_bank[step]), $sformatf("step %0d bank", step));
            check_value(32'(a), 32'(exp_addr[step]), $sformatf("step %0d address", step));
            held_cycles = 0;
            while (pin_cmd != CMD_NOP) begin
                held_cycles++;
                @(negedge clk);
            end
            check_value(held_cycles, `DDR2_CMD_CYCLES, $sformatf("step %0d hold", step));
            gap_cycles = 0;
            while (pin_cmd == CMD_NOP && !ready) begin
                gap_cycles++;
                check_value(32'(ba), 32'(exp_bank[step]),
                            $sformatf("step %0d bank during gap", step));
                check_value(32'(a), 32'(exp_addr[step]),
                            $sformatf("step %0d address during gap", step));
                @(negedge clk);
            end
            check_value(gap_cycles, exp_gap[step], $sformatf("step %0d NOP gap", step));
            if (step == `DDR2_NUM_STEPS - 1) begin
                check_value(32'(ready), 1, "ready after the last gap");
            end else begin
                check_value(32'({ready, odt}), 0, $sformatf("ready and odt after step %0d", step));
            end
            report_test($sformatf("step %0d command and gap", step), errors_before);
        end

        errors_before = error_count;
        check_value(32'(odt), 1, "odt rises with ready");
        for (cycle = 0; cycle < 100; cycle++) begin
            @(posedge clk);
            if (cycle == 0) begin
                init <= 1'b0;
            end else if (cycle == 40) begin
                init <= 1'b1; // A second init request must have no effect.
            end else if (cycle == 43) begin
                init <= 1'b0;
            end
            @(negedge clk);
            check_value(32'({ready, odt, cke}), 32'h7, "ready, odt and cke after ready");
            check_value(32'(pin_cmd), 32'(CMD_NOP), "command after ready");
        end
        report_test("ready and odt hold", errors_before);

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 pass_count + fail_count, pass_count, fail_count, error_count);
        if (error_count == 0 && fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: test/ddr2_init_sva.sv
`timescale 1ns/1ps

module ddr2_init_sva (
    input logic clk,
    input logic reset,
    input logic ready,
    input logic odt,
    input logic cke,
    input logic csbar,
    input logic rasbar,
    input logic casbar,
    input logic webar
);
    import ddr2_init_pkg::*;

    ddr2_cmd_t cmd;

    assign cmd = {csbar, rasbar, casbar, webar};

    ready_has_odt_cke: assert property (@(posedge clk) disable iff (reset)
        ready |-> (odt && cke))
        else $error("ready is high while odt or cke is low");

    ready_stays_high: assert property (@(posedge clk) disable iff (reset)
        !$fell(ready))
        else $error("ready fell while reset was low");

    cke_stays_high: assert property (@(posedge clk) disable iff (reset)
        !$fell(cke))
        else $error("cke fell while reset was low");

    // A command that follows a NOP must hold for a second cycle.
    command_second_cycle: assert property (@(posedge clk) disable iff (reset)
        (cmd != CMD_NOP && $past(cmd) == CMD_NOP) |=> (cmd == $past(cmd)))
        else $error("command was held for only one cycle");

    // The second cycle of a command must be followed by a NOP.
    command_ends: assert property (@(posedge clk) disable iff (reset)
        (cmd != CMD_NOP && $past(cmd) == cmd) |=> (cmd == CMD_NOP))
        else $error("command was held for more than two cycles");

endmodule

bind ddr2_init_top ddr2_init_sva u_ddr2_init_sva (
    .clk    (clk),
    .reset  (reset),
    .ready  (ready),
    .odt    (odt),
    .cke    (cke),
    .csbar  (csbar),
    .rasbar (rasbar),
    .casbar (casbar),
    .webar  (webar)
);

// File: design/ddr2_init_top.sv
`timescale 1ns/1ps
`include "ddr2_init_defines.svh"

module ddr2_init_top #(
    parameter logic [2:0]  burst_length     = `DDR2_BURST_LENGTH,
    parameter logic        burst_type       = `DDR2_BURST_TYPE,
    parameter logic [2:0]  cas_latency      = `DDR2_CAS_LATENCY,
    parameter logic [2:0]  additive_latency = `DDR2_ADDITIVE_LATENCY,
    parameter int unsigned power_up_cycles  = `DDR2_POWER_UP_CYCLES
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     init,
    output logic                     ready,
    output logic                     csbar,
    output logic                     rasbar,
    output logic                     casbar,
    output logic                     webar,
    output ddr2_init_pkg::ddr2_bank_t ba,
    output ddr2_init_pkg::ddr2_addr_t a,
    output logic                     cke,
    output logic                     odt
);
    import ddr2_init_pkg::*;

    ddr2_cmd_t cmd;

    ddr2_step_if u_step_if ();

    ddr2_init_rom #(
        .burst_length     (burst_length),
        .burst_type       (burst_type),
        .cas_latency      (cas_latency),
        .additive_latency (additive_latency)
    ) u_init_rom (
        .step_if (u_step_if.rom)
    );

    ddr2_init_sequencer #(
        .power_up_cycles (power_up_cycles)
    ) u_init_sequencer (
        .clk     (clk),
        .reset   (reset),
        .init    (init),
        .step_if (u_step_if.seq),
        .cmd     (cmd),
        .ba      (ba),
        .a       (a),
        .cke     (cke),
        .odt     (odt),
        .ready   (ready)
    );

    assign {csbar, rasbar, casbar, webar} = cmd;

endmodule

// File: design/ddr2_init_sequencer.sv
`timescale 1ns/1ps
`include "ddr2_init_defines.svh"

module ddr2_init_sequencer #(
    parameter int unsigned power_up_cycles = `DDR2_POWER_UP_CYCLES
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     init,
    ddr2_step_if.seq                 step_if,
    output ddr2_init_pkg::ddr2_cmd_t  cmd,
    output ddr2_init_pkg::ddr2_bank_t ba,
    output ddr2_init_pkg::ddr2_addr_t a,
    output logic                     cke,
    output logic                     odt,
    output logic                     ready
);
    import ddr2_init_pkg::*;

    localparam ddr2_step_t last_step = ddr2_step_t'(`DDR2_NUM_STEPS - 1);

    init_state_e state;
    init_state_e next_state;
    ddr2_step_t  step_q;
    ddr2_step_t  step_next;
    logic        load;
    ddr2_wait_t  load_value;
    logic        last;

    ddr2_wait_timer #(
        .width      (`DDR2_WAIT_WIDTH)
    ) u_wait_timer (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .load_value (load_value),
        .last       (last)
    );

    // The table is read with the step that the next command will use.
    assign step_if.step = step_next;

    always_comb begin
        next_state = state;
        step_next  = step_q;
        load       = 1'b0;
        load_value = '0;
        case (state)
            st_idle: begin
                if (init) begin
                    next_state = st_power_up;
                    load       = 1'b1;
                    load_value = ddr2_wait_t'(power_up_cycles - 1);
                end
            end
            st_power_up: begin
                if (last) begin
                    next_state = st_cke_settle;
                    load       = 1'b1;
                    load_value = ddr2_wait_t'(`DDR2_CKE_SETTLE_CYCLES - 1);
                end
            end
            st_cke_settle: begin
                if (last) begin
                    next_state = st_command;
                    load       = 1'b1;
                    load_value = ddr2_wait_t'(`DDR2_CMD_CYCLES - 1);
                end
            end
            st_command: begin
                if (last) begin
                    next_state = st_gap;
                    load       = 1'b1;
                    load_value = step_if.gap - 1'b1;
                end
            end
            st_gap: begin
                if (last) begin
                    if (step_q == last_step) begin
                        next_state = st_ready;
                    end else begin
                        next_state = st_command;
                        step_next  = step_q + 1'b1;
                        load       = 1'b1;
                        load_value = ddr2_wait_t'(`DDR2_CMD_CYCLES - 1);
                    end
                end
            end
            st_ready: begin
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // Pins update on the same edge as the state they belong to.
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= st_idle;
            step_q <= '0;
            cmd    <= CMD_NOP;
            ba     <= '0;
            a      <= '0;
            cke    <= 1'b0;
            odt    <= 1'b0;
            ready  <= 1'b0;
        end else begin
            state  <= next_state;
            step_q <= step_next;
            if (next_state != state) begin
                case (next_state)
                    st_cke_settle: cke <= 1'b1;
                    st_command: begin
                        cmd <= step_if.cmd;
                        ba  <= step_if.bank;
                        a   <= step_if.addr;
                    end
                    st_gap: cmd <= CMD_NOP; // Bank and address keep their values.
                    st_ready: begin
                        odt   <= 1'b1;
                        ready <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// File: design/ddr2_init_rom.sv
`timescale 1ns/1ps
`include "ddr2_init_defines.svh"

module ddr2_init_rom #(
    parameter logic [2:0] burst_length     = `DDR2_BURST_LENGTH,
    parameter logic       burst_type       = `DDR2_BURST_TYPE,
    parameter logic [2:0] cas_latency      = `DDR2_CAS_LATENCY,
    parameter logic [2:0] additive_latency = `DDR2_ADDITIVE_LATENCY
) (
    ddr2_step_if.rom step_if
);
    import ddr2_init_pkg::*;

    localparam ddr2_addr_t precharge_all_addr = ddr2_addr_t'(1 << 10); // A10 selects all banks.

    function automatic ddr2_addr_t mr_word(input logic dll_reset);
        ddr2_addr_t word;
        word        = '0;
        word[2:0]   = burst_length;
        word[3]     = burst_type;
        word[6:4]   = cas_latency;
        word[8]     = dll_reset;
        word[11:9]  = `DDR2_WRITE_RECOVERY;
        return word;
    endfunction

    // A0 low keeps the DLL enabled. OCD default sets A9-A7 and A2 together.
    function automatic ddr2_addr_t emr1_word(input logic ocd_default);
        ddr2_addr_t word;
        word        = '0;
        word[2]     = ocd_default;
        word[5:3]   = additive_latency;
        word[9:7]   = {3{ocd_default}};
        word[10]    = 1'b1;
        return word;
    endfunction

    always_comb begin
        step_if.cmd  = CMD_NOP;
        step_if.bank = '0;
        step_if.addr = '0;
        step_if.gap  = '0;
        case (step_if.step)
            4'd0, 4'd5, 4'd11: begin
                step_if.cmd  = CMD_PRECHARGE;
                step_if.addr = precharge_all_addr;
                step_if.gap  = ddr2_wait_t'(`DDR2_RP_GAP);
            end
            4'd1: begin
                step_if.cmd  = CMD_LOAD_MODE; // EMR2 loads zero.
                step_if.bank = ddr2_bank_t'(2);
                step_if.gap  = ddr2_wait_t'(`DDR2_MRD_GAP);
            end
            4'd2: begin
                step_if.cmd  = CMD_LOAD_MODE; // EMR3 loads zero.
                step_if.bank = ddr2_bank_t'(3);
                step_if.gap  = ddr2_wait_t'(`DDR2_MRD_GAP);
            end
            4'd3, 4'd10: begin
                step_if.cmd  = CMD_LOAD_MODE;
                step_if.bank = ddr2_bank_t'(1);
                step_if.addr = emr1_word(1'b0);
                step_if.gap  = ddr2_wait_t'(`DDR2_MRD_GAP);
            end
            4'd4: begin
                step_if.cmd  = CMD_LOAD_MODE;
                step_if.addr = mr_word(1'b1); // First MR resets the DLL.
                step_if.gap  = ddr2_wait_t'(`DDR2_MRD_GAP);
            end
            4'd6, 4'd7: begin
                step_if.cmd  = CMD_REFRESH;
                step_if.gap  = ddr2_wait_t'(`DDR2_RFC_GAP);
            end
            4'd8: begin
                step_if.cmd  = CMD_LOAD_MODE;
                step_if.addr = mr_word(1'b0);
                step_if.gap  = ddr2_wait_t'(`DDR2_DLL_GAP);
            end
            4'd9: begin
                step_if.cmd  = CMD_LOAD_MODE;
                step_if.bank = ddr2_bank_t'(1);
                step_if.addr = emr1_word(1'b1);
                step_if.gap  = ddr2_wait_t'(`DDR2_MRD_GAP);
            end
            default: begin
            end
        endcase
    end

endmodule

// File: design/ddr2_wait_timer.sv
`timescale 1ns/1ps

module ddr2_wait_timer #(
    parameter int width = 17
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             load,
    input  logic [width-1:0] load_value,
    output logic             last
);

    logic [width-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (count != '0) begin
            count <= count - 1'b1; // Holds at zero once a phase has ended.
        end
    end

    // The loaded value is the phase length minus one.
    assign last = (count == '0);

endmodule

// File: design/ddr2_step_if.sv
`timescale 1ns/1ps

interface ddr2_step_if;
    import ddr2_init_pkg::*;

    ddr2_step_t step;
    ddr2_cmd_t  cmd;
    ddr2_bank_t bank;
    ddr2_addr_t addr;
    ddr2_wait_t gap; // NOP cycles that follow the command.

    modport seq (
        output step,
        input  cmd, bank, addr, gap
    );

    modport rom (
        input  step,
        output cmd, bank, addr, gap
    );

endinterface

// File: design/ddr2_init_pkg.sv
`include "ddr2_init_defines.svh"

package ddr2_init_pkg;

    typedef logic [`DDR2_ADDR_WIDTH-1:0] ddr2_addr_t;
    typedef logic [`DDR2_BANK_WIDTH-1:0] ddr2_bank_t;
    typedef logic [`DDR2_WAIT_WIDTH-1:0] ddr2_wait_t;
    typedef logic [3:0] ddr2_step_t;

    // Command bits are {csbar, rasbar, casbar, webar}, all active low.
    typedef logic [3:0] ddr2_cmd_t;

    localparam ddr2_cmd_t CMD_NOP       = 4'b0111;
    localparam ddr2_cmd_t CMD_LOAD_MODE = 4'b0000;
    localparam ddr2_cmd_t CMD_REFRESH   = 4'b0001;
    localparam ddr2_cmd_t CMD_PRECHARGE = 4'b0010;

    typedef enum logic [2:0] {
        st_idle,
        st_power_up,
        st_cke_settle,
        st_command,
        st_gap,
        st_ready
    } init_state_e;

endpackage

// File: design/ddr2_init_defines.svh
`ifndef DDR2_INIT_DEFINES_SVH
`define DDR2_INIT_DEFINES_SVH

// Bus and counter widths.
`define DDR2_ADDR_WIDTH 13
`define DDR2_BANK_WIDTH 2
`define DDR2_WAIT_WIDTH 17

`define DDR2_NUM_STEPS 12 // Commands in the init sequence.

// Phase lengths in clock cycles.
`define DDR2_POWER_UP_CYCLES 100001
`define DDR2_CKE_SETTLE_CYCLES 200
`define DDR2_CMD_CYCLES 2

// NOP gaps that follow each kind of command.
`define DDR2_MRD_GAP 4
`define DDR2_RP_GAP 8
`define DDR2_RFC_GAP 400
`define DDR2_DLL_GAP 406 // Covers DLL lock after the second MR load.

// Default mode register fields.
`define DDR2_BURST_LENGTH 3'b011
`define DDR2_BURST_TYPE 1'b0
`define DDR2_CAS_LATENCY 3'b100
`define DDR2_ADDITIVE_LATENCY 3'b100
`define DDR2_WRITE_RECOVERY 3'b011

`endif
